//--- sim.f
+incdir+logic
logic/tlb_pkg.sv
logic/tlb_entry_regs.sv
logic/tlb_match_stage.sv
logic/tlb_xlat_stage.sv
logic/tlb_top.sv
testbench/tlb_tb.sv

//--- testbench/tlb_tb.sv
// ################################################
// TLB testbench
// Drives the configuration port and both channels
// and checks results against a reference table
// ################################################

`timescale 1ns/1ps

`include "tlb_consts.svh"

// Result checks for one translation channel
module result_checker #(
  parameter string chan = "rd"
) (
  input logic               clk_i,
  input logic               rst_n_i,
  input tlb_pkg::xlat_res_t res_i,
  input logic               res_valid_i,
  input logic               res_ready_i,
  input logic               req_xfer_i,
  input tlb_pkg::xlat_res_t exp_i,
  input logic               exp_empty_i
);

  import tlb_pkg::*;

  int        fails = 0;
  xlat_res_t prev_res;

  // Previous cycle's result, shown when a stalled result moves
  always @(posedge clk_i) begin
    prev_res <= res_i;
  end

  // Nothing comes out that was not asked for
  a_outstanding: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      res_valid_i |-> !exp_empty_i)
    else begin
      fails++;
      $display("[%0t] %s channel gave a result with no request outstanding", $time, chan);
    end

  // Result equals the oldest expected entry
  a_value: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      res_valid_i && !exp_empty_i |-> res_i == exp_i)
    else begin
      fails++;
      $display("Mismatch at %0t: %s_res_o expected %h got %h",
               $time, chan, $sampled(exp_i), $sampled(res_i));
    end

  a_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      res_valid_i && !res_ready_i |=> res_valid_i && $stable(res_i))
    else begin
      fails++;
      $display("Mismatch at %0t: %s_res_o stalled expected valid 1 data %h got valid %b data %h",
               $time, chan, $sampled(prev_res), $sampled(res_valid_i), $sampled(res_i));
    end

  // Transfer at one edge, translate stage loads at the next
  a_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      res_ready_i && $past(req_xfer_i) |=> res_valid_i)
    else begin
      fails++;
      $display("[%0t] %s result did not arrive 2 cycles after its request", $time, chan);
    end

  // An empty pipeline gives no result one cycle after a request
  a_early: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      req_xfer_i && exp_empty_i |=> !res_valid_i)
    else begin
      fails++;
      $display("[%0t] %s result arrived 1 cycle after its request", $time, chan);
    end

endmodule

module tlb_tb;

  import tlb_pkg::*;

  localparam int n_req = 32;
  localparam int n_bp  = 48;
  // Reset, readback, table setup, four translation tests, stalled test, margin
  localparam int budget_cycles = 3 + 32 + 28 + 4 * (n_req + 10) + 4 * n_bp + 200;

  logic      clk_i;
  logic      rst_n_i;
  cfg_req_t  cfg_req_i;
  logic      cfg_req_valid_i, cfg_req_ready_o;
  cfg_rsp_t  cfg_rsp_o;
  logic      cfg_rsp_valid_o, cfg_rsp_ready_i;
  xlat_req_t rd_req_i, wr_req_i;
  logic      rd_req_valid_i, rd_req_ready_o, wr_req_valid_i, wr_req_ready_o;
  xlat_res_t rd_res_o, wr_res_o;
  logic      rd_res_valid_o, rd_res_ready_i, wr_res_valid_o, wr_res_ready_i;

  // Reference table and expected results in order
  entry_t                     model [`TLB_NUM_ENTRIES];
  xlat_res_t                  rd_q [$];
  xlat_res_t                  wr_q [$];
  logic [`TLB_CFG_DATA_W-1:0] cfg_q [$];
  xlat_res_t                  rd_head, wr_head;
  logic [`TLB_CFG_DATA_W-1:0] cfg_head;
  logic                       rd_empty = 1'b1;
  logic                       wr_empty = 1'b1;
  logic                       cfg_empty = 1'b1;

  int seed      = 51;
  int cfg_fails = 0;
  int checked   = 0;
  int tests     = 0;
  int err_mark  = 0;
  bit bp_busy   = 1'b0;

  tlb_top uut (.*);

  result_checker #(.chan("rd")) u_rd_chk (
    .clk_i       ( clk_i                           ),
    .rst_n_i     ( rst_n_i                         ),
    .res_i       ( rd_res_o                        ),
    .res_valid_i ( rd_res_valid_o                  ),
    .res_ready_i ( rd_res_ready_i                  ),
    .req_xfer_i  ( rd_req_valid_i & rd_req_ready_o ),
    .exp_i       ( rd_head                         ),
    .exp_empty_i ( rd_empty                        )
  );

  result_checker #(.chan("wr")) u_wr_chk (
    .clk_i       ( clk_i                           ),
    .rst_n_i     ( rst_n_i                         ),
    .res_i       ( wr_res_o                        ),
    .res_valid_i ( wr_res_valid_o                  ),
    .res_ready_i ( wr_res_ready_i                  ),
    .req_xfer_i  ( wr_req_valid_i & wr_req_ready_o ),
    .exp_i       ( wr_head                         ),
    .exp_empty_i ( wr_empty                        )
  );

  // Read-back data, zero for writes, in request order
  a_cfg_rsp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      cfg_rsp_valid_o |-> !cfg_empty && cfg_rsp_o.rdata == cfg_head)
    else begin
      cfg_fails++;
      $display("Mismatch at %0t: cfg_rsp_o expected %h got %h",
               $time, $sampled(cfg_head), $sampled(cfg_rsp_o.rdata));
    end

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Lowest index that is valid, permitted and in range wins
  function automatic xlat_res_t expect_xlat(logic [`TLB_INP_ADDR_W-1:0] addr, bit wr);
    xlat_res_t res;
    inp_page_t page;
    res  = '0;
    page = addr[`TLB_INP_ADDR_W-1:`TLB_PAGE_OFS_W];
    for (int i = 0; i < `TLB_NUM_ENTRIES; i++) begin
      if (!res.hit && model[i].flags.valid
          && (wr ? model[i].flags.writable : model[i].flags.readable)
          && page >= model[i].first && page <= model[i].last) begin
        res.hit  = 1'b1;
        res.addr = {oup_page_t'(model[i].base + (page - model[i].first)),
                    addr[`TLB_PAGE_OFS_W-1:0]};
      end
    end
    return res;
  endfunction

  function automatic logic [`TLB_CFG_DATA_W-1:0] expect_rsp(cfg_req_t req);
    logic [`TLB_CFG_DATA_W-1:0] rdata;
    rdata = '0;
    if (req.op == CFG_OP_READ) begin
      case (req.field)
        CFG_FIELD_FIRST: rdata[$bits(inp_page_t)-1:0] = model[req.idx].first;
        CFG_FIELD_LAST:  rdata[$bits(inp_page_t)-1:0] = model[req.idx].last;
        CFG_FIELD_BASE:  rdata[$bits(oup_page_t)-1:0] = model[req.idx].base;
        default:         rdata[$bits(flags_t)-1:0] = model[req.idx].flags;
      endcase
    end
    return rdata;
  endfunction

  // Only the low bits of the write data land in the field
  function automatic void update_model(cfg_req_t req);
    case (req.field)
      CFG_FIELD_FIRST: model[req.idx].first = req.wdata[$bits(inp_page_t)-1:0];
      CFG_FIELD_LAST:  model[req.idx].last = req.wdata[$bits(inp_page_t)-1:0];
      CFG_FIELD_BASE:  model[req.idx].base = req.wdata[$bits(oup_page_t)-1:0];
      default:         model[req.idx].flags = req.wdata[$bits(flags_t)-1:0];
    endcase
  endfunction

  function automatic int total_errors();
    return cfg_fails + u_rd_chk.fails + u_wr_chk.fails;
  endfunction

  // Model and queues advance at every transfer edge
  always @(posedge clk_i) begin
    if (rst_n_i) begin
      if (rd_res_valid_o && rd_res_ready_i && rd_q.size() > 0) begin
        void'(rd_q.pop_front());
        checked++;
      end
      if (wr_res_valid_o && wr_res_ready_i && wr_q.size() > 0) begin
        void'(wr_q.pop_front());
        checked++;
      end
      if (cfg_rsp_valid_o && cfg_rsp_ready_i && cfg_q.size() > 0) begin
        void'(cfg_q.pop_front());
      end
      // Requests on the edge of a table write still see the old table
      if (rd_req_valid_i && rd_req_ready_o) begin
        rd_q.push_back(expect_xlat(rd_req_i.addr, 1'b0));
      end
      if (wr_req_valid_i && wr_req_ready_o) begin
        wr_q.push_back(expect_xlat(wr_req_i.addr, 1'b1));
      end
      if (cfg_req_valid_i && cfg_req_ready_o) begin
        cfg_q.push_back(expect_rsp(cfg_req_i));
        if (cfg_req_i.op == CFG_OP_WRITE) begin
          update_model(cfg_req_i);
        end
      end
    end
    rd_empty  = (rd_q.size() == 0);
    rd_head   = rd_empty ? '0 : rd_q[0];
    wr_empty  = (wr_q.size() == 0);
    wr_head   = wr_empty ? '0 : wr_q[0];
    cfg_empty = (cfg_q.size() == 0);
    cfg_head  = cfg_empty ? '0 : cfg_q[0];
  end

  // Called 1 ns after an edge, returns 1 ns after the transfer edge
  task automatic drive_cfg(input cfg_op_e op, input cfg_field_e field, input int idx,
                           input logic [`TLB_CFG_DATA_W-1:0] data);
    cfg_req_i.op    = op;
    cfg_req_i.field = field;
    cfg_req_i.idx   = entry_idx_t'(idx);
    cfg_req_i.wdata = data;
    cfg_req_valid_i = 1'b1;
    @(negedge clk_i);
    while (!cfg_req_ready_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    cfg_req_valid_i = 1'b0;
  endtask

  task automatic set_entry(input int idx, input int first, input int last, input int base,
                           input logic [2:0] flags);
    drive_cfg(CFG_OP_WRITE, CFG_FIELD_FIRST, idx, first);
    drive_cfg(CFG_OP_WRITE, CFG_FIELD_LAST, idx, last);
    drive_cfg(CFG_OP_WRITE, CFG_FIELD_BASE, idx, base);
    drive_cfg(CFG_OP_WRITE, CFG_FIELD_FLAGS, idx, flags);
  endtask

  task automatic send_req(input bit wr, input logic [`TLB_INP_ADDR_W-1:0] addr);
    if (wr) begin
      wr_req_i.addr  = addr;
      wr_req_valid_i = 1'b1;
    end else begin
      rd_req_i.addr  = addr;
      rd_req_valid_i = 1'b1;
    end
    @(negedge clk_i);
    while (wr ? !wr_req_ready_o : !rd_req_ready_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    if (wr) begin
      wr_req_valid_i = 1'b0;
    end else begin
      rd_req_valid_i = 1'b0;
    end
  endtask

  // Random pages in lo..lo+span-1, random offsets
  task automatic send_burst(input bit wr, input int n, input int lo, input int span);
    logic [`TLB_INP_ADDR_W-1:0] addr;
    repeat (n) begin
      addr[`TLB_INP_ADDR_W-1:`TLB_PAGE_OFS_W] = inp_page_t'(lo + $unsigned($random(seed)) % span);
      addr[`TLB_PAGE_OFS_W-1:0] = `TLB_PAGE_OFS_W'($random(seed));
      send_req(wr, addr);
    end
  endtask

  task automatic dual_burst(input int n, input int lo, input int span);
    fork
      send_burst(1'b0, n, lo, span);
      send_burst(1'b1, n, lo, span);
    join
  endtask

  // Wait until every expected item has come back
  task automatic drain();
    @(negedge clk_i);
    while (rd_q.size() != 0 || wr_q.size() != 0 || cfg_q.size() != 0) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic finish_test(input string name);
    int errs;
    errs     = total_errors() - err_mark;
    err_mark = total_errors();
    tests++;
    $display("[%0t] %s: %s, %0d errors", $time, name, errs == 0 ? "ok" : "failed", errs);
  endtask

  initial begin
    #(budget_cycles * 10);
    $display("Watchdog expired after %0d cycles, the run did not complete", budget_cycles);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    rst_n_i         = 1'b0;
    cfg_req_i       = '0;
    cfg_req_valid_i = 1'b0;
    cfg_rsp_ready_i = 1'b1;
    rd_req_i        = '0;
    rd_req_valid_i  = 1'b0;
    rd_res_ready_i  = 1'b1;
    wr_req_i        = '0;
    wr_req_valid_i  = 1'b0;
    wr_res_ready_i  = 1'b1;
    foreach (model[i]) begin
      model[i] = '0;
    end
    repeat (3) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    // Every field of entries 0 to 3 written with random data, then read
    for (int i = 0; i < 4; i++) begin
      for (int f = 0; f < 4; f++) begin
        drive_cfg(CFG_OP_WRITE, cfg_field_e'(f), i, $random(seed));
        drive_cfg(CFG_OP_READ, cfg_field_e'(f), i, '0);
      end
    end
    drain();
    finish_test("cfg_readback");

    // Flags are {writable, readable, valid}
    // Entry 7 stays invalid
    set_entry(0, 'h00100, 'h001ff, 'h80000, 3'b111);
    set_entry(1, 'h00200, 'h0020f, 'h40000, 3'b011);
    set_entry(2, 'h00300, 'h0030f, 'h50000, 3'b101);
    set_entry(3, 'h00180, 'h001ff, 'h60000, 3'b111);
    set_entry(4, 'h00500, 'h005ff, 'h70000, 3'b110);
    set_entry(5, 'h00600, 'h0060f, 'h30000, 3'b011);
    set_entry(6, 'h00600, 'h006ff, 'h20000, 3'b111);
    drain();

    dual_burst(n_req, 'h00100, 'h100);
    drain();
    finish_test("hit");

    // No range, an invalid entry, and far above every range
    dual_burst(n_req / 4, 'h00000, 'h100);
    dual_burst(n_req / 4, 'h00700, 'hf8000);
    dual_burst(n_req / 2, 'h00500, 'h100);
    drain();
    finish_test("miss");

    // Entry 1 read only, entry 2 write only
    dual_burst(n_req / 2, 'h00200, 'h10);
    dual_burst(n_req / 2, 'h00300, 'h10);
    drain();
    finish_test("permissions");

    // Entry 0 over entry 3, entry 5 over 6 for reads only
    dual_burst(n_req / 2, 'h00180, 'h80);
    dual_burst(n_req / 2, 'h00600, 'h100);
    drain();
    finish_test("priority");

    // Random result ready, entry 0 base rewritten mid-stream
    // Every page in the burst translates through entry 0
    bp_busy = 1'b1;
    fork
      begin
        while (bp_busy) begin
          rd_res_ready_i = 1'($random(seed));
          wr_res_ready_i = 1'($random(seed));
          @(posedge clk_i);
          #1;
        end
      end
      begin
        fork
          dual_burst(n_bp, 'h00100, 'h100);
          begin
            repeat (12) @(posedge clk_i);
            #1;
            drive_cfg(CFG_OP_WRITE, CFG_FIELD_BASE, 0, 'h90000);
          end
        join
        bp_busy = 1'b0;
      end
    join
    rd_res_ready_i = 1'b1;
    wr_res_ready_i = 1'b1;
    drain();
    finish_test("backpressure_snapshot");

    $display("Summary: %0d tests, %0d results checked, %0d errors",
             tests, checked, total_errors());
    if (total_errors() == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- logic/tlb_top.sv
// ################################################
// TLB top level
// One shared table feeding a read and a write
// translation pipeline
// ################################################

`timescale 1ns/1ps

`include "tlb_consts.svh"

module tlb_top (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // Configuration port
  input  tlb_pkg::cfg_req_t  cfg_req_i,
  input  logic               cfg_req_valid_i,
  output logic               cfg_req_ready_o,
  output tlb_pkg::cfg_rsp_t  cfg_rsp_o,
  output logic               cfg_rsp_valid_o,
  input  logic               cfg_rsp_ready_i,
  // Read channel
  input  tlb_pkg::xlat_req_t rd_req_i,
  input  logic               rd_req_valid_i,
  output logic               rd_req_ready_o,
  output tlb_pkg::xlat_res_t rd_res_o,
  output logic               rd_res_valid_o,
  input  logic               rd_res_ready_i,
  // Write channel
  input  tlb_pkg::xlat_req_t wr_req_i,
  input  logic               wr_req_valid_i,
  output logic               wr_req_ready_o,
  output tlb_pkg::xlat_res_t wr_res_o,
  output logic               wr_res_valid_o,
  input  logic               wr_res_ready_i
);

  import tlb_pkg::*;

  // Table contents seen by both channels
  entry_t [`TLB_NUM_ENTRIES-1:0] entries;

  // Stage to stage links
  match_t rd_match;
  logic   rd_match_valid;
  logic   rd_match_ready;
  match_t wr_match;
  logic   wr_match_valid;
  logic   wr_match_ready;

  tlb_entry_regs u_entry_regs (
    .clk_i           ( clk_i           ),
    .rst_n_i         ( rst_n_i         ),
    .cfg_req_i       ( cfg_req_i       ),
    .cfg_req_valid_i ( cfg_req_valid_i ),
    .cfg_req_ready_o ( cfg_req_ready_o ),
    .cfg_rsp_o       ( cfg_rsp_o       ),
    .cfg_rsp_valid_o ( cfg_rsp_valid_o ),
    .cfg_rsp_ready_i ( cfg_rsp_ready_i ),
    .entries_o       ( entries         )
  );

  // Read channel checks the readable flag
  tlb_match_stage #(
    .is_write_chan ( 1'b0 )
  ) u_rd_match (
    .clk_i         ( clk_i          ),
    .rst_n_i       ( rst_n_i        ),
    .entries_i     ( entries        ),
    .req_i         ( rd_req_i       ),
    .req_valid_i   ( rd_req_valid_i ),
    .req_ready_o   ( rd_req_ready_o ),
    .match_o       ( rd_match       ),
    .match_valid_o ( rd_match_valid ),
    .match_ready_i ( rd_match_ready )
  );

  tlb_xlat_stage u_rd_xlat (
    .clk_i         ( clk_i          ),
    .rst_n_i       ( rst_n_i        ),
    .match_i       ( rd_match       ),
    .match_valid_i ( rd_match_valid ),
    .match_ready_o ( rd_match_ready ),
    .res_o         ( rd_res_o       ),
    .res_valid_o   ( rd_res_valid_o ),
    .res_ready_i   ( rd_res_ready_i )
  );

  // Write channel checks the writable flag
  tlb_match_stage #(
    .is_write_chan ( 1'b1 )
  ) u_wr_match (
    .clk_i         ( clk_i          ),
    .rst_n_i       ( rst_n_i        ),
    .entries_i     ( entries        ),
    .req_i         ( wr_req_i       ),
    .req_valid_i   ( wr_req_valid_i ),
    .req_ready_o   ( wr_req_ready_o ),
    .match_o       ( wr_match       ),
    .match_valid_o ( wr_match_valid ),
    .match_ready_i ( wr_match_ready )
  );

  tlb_xlat_stage u_wr_xlat (
    .clk_i         ( clk_i          ),
    .rst_n_i       ( rst_n_i        ),
    .match_i       ( wr_match       ),
    .match_valid_i ( wr_match_valid ),
    .match_ready_o ( wr_match_ready ),
    .res_o         ( wr_res_o       ),
    .res_valid_o   ( wr_res_valid_o ),
    .res_ready_i   ( wr_res_ready_i )
  );

endmodule

//--- logic/tlb_xlat_stage.sv
// ################################################
// TLB translate stage
// Forms the output address from the snapshot and
// holds the result until it is taken
// ################################################

`timescale 1ns/1ps

`include "tlb_consts.svh"

module tlb_xlat_stage (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  tlb_pkg::match_t    match_i,
  input  logic               match_valid_i,
  output logic               match_ready_o,
  output tlb_pkg::xlat_res_t res_o,
  output logic               res_valid_o,
  input  logic               res_ready_i
);

  import tlb_pkg::*;

  inp_page_t page_dist;
  oup_page_t oup_page;
  xlat_res_t res_d;
  xlat_res_t res_q;
  logic      res_valid_q;
  logic      match_fire;

  // Distance of the page from the start of the range
  assign page_dist = match_i.addr[`TLB_INP_ADDR_W-1:`TLB_PAGE_OFS_W] - match_i.first;
  assign oup_page  = match_i.base + oup_page_t'(page_dist);

  // Miss gives zero address
  always_comb begin
    res_d.hit  = match_i.hit;
    res_d.addr = '0;
    if (match_i.hit) begin
      res_d.addr = {oup_page, match_i.addr[`TLB_PAGE_OFS_W-1:0]};
    end
  end

  // Same one-entry rule as the match stage
  assign match_ready_o = ~res_valid_q | res_ready_i;
  assign match_fire    = match_valid_i & match_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      res_valid_q <= 1'b0;
    end else if (match_fire) begin
      res_valid_q <= 1'b1;
    end else if (res_ready_i) begin
      res_valid_q <= 1'b0;
    end
  end

  // Result stays stable under back-pressure
  always_ff @(posedge clk_i) begin
    if (match_fire) begin
      res_q <= res_d;
    end
  end

  assign res_o       = res_q;
  assign res_valid_o = res_valid_q;

endmodule

//--- logic/tlb_match_stage.sv
// ################################################
// TLB match stage
// Finds the lowest valid, permitted entry covering
// the request page and registers a snapshot of it
// ################################################

`timescale 1ns/1ps

`include "tlb_consts.svh"

module tlb_match_stage #(
  // Selects the writable flag instead of readable
  parameter bit is_write_chan = 1'b0
) (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  tlb_pkg::entry_t [`TLB_NUM_ENTRIES-1:0] entries_i,
  input  tlb_pkg::xlat_req_t                     req_i,
  input  logic                                   req_valid_i,
  output logic                                   req_ready_o,
  output tlb_pkg::match_t                        match_o,
  output logic                                   match_valid_o,
  input  logic                                   match_ready_i
);

  import tlb_pkg::*;

  inp_page_t                   req_page;
  logic [`TLB_NUM_ENTRIES-1:0] entry_hits;
  entry_idx_t                  match_idx;
  logic                        match_any;
  match_t                      match_d;
  match_t                      match_q;
  logic                        match_valid_q;
  logic                        req_fire;

  // Page number of the request
  assign req_page = req_i.addr[`TLB_INP_ADDR_W-1:`TLB_PAGE_OFS_W];

  // Range, valid and permission check per entry
  always_comb begin
    for (int i = 0; i < `TLB_NUM_ENTRIES; i++) begin
      entry_hits[i] = entries_i[i].flags.valid
          & (is_write_chan ? entries_i[i].flags.writable : entries_i[i].flags.readable)
          & (req_page >= entries_i[i].first)
          & (req_page <= entries_i[i].last);
    end
  end

  // Priority scan from the top down
  // so the lowest hitting index is written last
  always_comb begin
    match_idx = '0;
    match_any = 1'b0;
    for (int i = `TLB_NUM_ENTRIES - 1; i >= 0; i--) begin
      if (entry_hits[i]) begin
        match_idx = entry_idx_t'(i);
        match_any = 1'b1;
      end
    end
  end

  // Snapshot of the winning entry
  // Pages forced to zero on a miss
  always_comb begin
    match_d.addr  = req_i.addr;
    match_d.hit   = match_any;
    match_d.first = match_any ? entries_i[match_idx].first : '0;
    match_d.base  = match_any ? entries_i[match_idx].base : '0;
  end

  // Accept when empty or the next stage drains this one
  assign req_ready_o = ~match_valid_q | match_ready_i;
  assign req_fire    = req_valid_i & req_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      match_valid_q <= 1'b0;
    end else if (req_fire) begin
      match_valid_q <= 1'b1;
    end else if (match_ready_i) begin
      match_valid_q <= 1'b0;
    end
  end

  // Payload held until the next transfer, later table writes don't reach it
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      match_q <= match_d;
    end
  end

  assign match_o       = match_q;
  assign match_valid_o = match_valid_q;

endmodule

//--- logic/tlb_entry_regs.sv
// ################################################
// TLB entry registers
// Translation table in flip-flops, filled and read
// back through a valid/ready configuration port
// ################################################

`timescale 1ns/1ps

`include "tlb_consts.svh"

module tlb_entry_regs (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  tlb_pkg::cfg_req_t                      cfg_req_i,
  input  logic                                   cfg_req_valid_i,
  output logic                                   cfg_req_ready_o,
  output tlb_pkg::cfg_rsp_t                      cfg_rsp_o,
  output logic                                   cfg_rsp_valid_o,
  input  logic                                   cfg_rsp_ready_i,
  output tlb_pkg::entry_t [`TLB_NUM_ENTRIES-1:0] entries_o
);

  import tlb_pkg::*;

  // Table storage
  entry_t [`TLB_NUM_ENTRIES-1:0] entries_q;

  // One-deep response buffer
  cfg_rsp_t rsp_q;
  logic     rsp_valid_q;

  logic                       req_fire;
  logic                       wr_en;
  logic [`TLB_CFG_DATA_W-1:0] rdata;

  // Accept when no response waits or it leaves this cycle
  assign cfg_req_ready_o = ~rsp_valid_q | cfg_rsp_ready_i;
  assign req_fire        = cfg_req_valid_i & cfg_req_ready_o;
  assign wr_en           = req_fire & (cfg_req_i.op == CFG_OP_WRITE);

  // Read-back mux, fields zero-extended
  // Writes answer with zero
  always_comb begin
    rdata = '0;
    if (cfg_req_i.op == CFG_OP_READ) begin
      case (cfg_req_i.field)
        CFG_FIELD_FIRST: rdata = `TLB_CFG_DATA_W'(entries_q[cfg_req_i.idx].first);
        CFG_FIELD_LAST:  rdata = `TLB_CFG_DATA_W'(entries_q[cfg_req_i.idx].last);
        CFG_FIELD_BASE:  rdata = `TLB_CFG_DATA_W'(entries_q[cfg_req_i.idx].base);
        CFG_FIELD_FLAGS: rdata = `TLB_CFG_DATA_W'(entries_q[cfg_req_i.idx].flags);
        default:         rdata = '0;
      endcase
    end
  end

  // Field update at the transfer edge
  // Only the low bits of wdata are kept
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      // All entries start invalid
      entries_q <= '0;
    end else if (wr_en) begin
      case (cfg_req_i.field)
        CFG_FIELD_FIRST: begin
          entries_q[cfg_req_i.idx].first <= cfg_req_i.wdata[$bits(inp_page_t)-1:0];
        end
        CFG_FIELD_LAST: begin
          entries_q[cfg_req_i.idx].last <= cfg_req_i.wdata[$bits(inp_page_t)-1:0];
        end
        CFG_FIELD_BASE: begin
          entries_q[cfg_req_i.idx].base <= cfg_req_i.wdata[$bits(oup_page_t)-1:0];
        end
        CFG_FIELD_FLAGS: begin
          entries_q[cfg_req_i.idx].flags <= cfg_req_i.wdata[$bits(flags_t)-1:0];
        end
        default: begin
          entries_q <= entries_q;
        end
      endcase
    end
  end

  // Response valid, set by a request and cleared when taken
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else if (req_fire) begin
      rsp_valid_q <= 1'b1;
    end else if (cfg_rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // Response data, loaded with the request
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      rsp_q.rdata <= rdata;
    end
  end

  assign cfg_rsp_o       = rsp_q;
  assign cfg_rsp_valid_o = rsp_valid_q;
  assign entries_o       = entries_q;

endmodule

//--- logic/tlb_pkg.sv
// ################################################
// TLB package
// Table entry, translation, pipeline payload and
// configuration port types
// ################################################

`include "tlb_consts.svh"

package tlb_pkg;

  // Page numbers in both address spaces
  typedef logic [`TLB_INP_ADDR_W-`TLB_PAGE_OFS_W-1:0] inp_page_t;
  typedef logic [`TLB_OUP_ADDR_W-`TLB_PAGE_OFS_W-1:0] oup_page_t;

  // Index into the table
  typedef logic [$clog2(`TLB_NUM_ENTRIES)-1:0] entry_idx_t;

  // Access permissions and valid bit of one entry
  typedef struct packed {
    logic writable;
    logic readable;
    logic valid;
  } flags_t;

  // One entry maps the inclusive range first..last onto base
  typedef struct packed {
    flags_t    flags;
    oup_page_t base;
    inp_page_t last;
    inp_page_t first;
  } entry_t;

  typedef struct packed {
    logic [`TLB_INP_ADDR_W-1:0] addr;
  } xlat_req_t;

  typedef struct packed {
    logic                       hit;
    logic [`TLB_OUP_ADDR_W-1:0] addr;
  } xlat_res_t;

  // Match stage to translate stage payload
  typedef struct packed {
    logic [`TLB_INP_ADDR_W-1:0] addr;
    logic                       hit;
    inp_page_t                  first;
    oup_page_t                  base;
  } match_t;

  typedef enum logic {
    CFG_OP_READ,
    CFG_OP_WRITE
  } cfg_op_e;

  typedef enum logic [1:0] {
    CFG_FIELD_FIRST,
    CFG_FIELD_LAST,
    CFG_FIELD_BASE,
    CFG_FIELD_FLAGS
  } cfg_field_e;

  typedef struct packed {
    cfg_op_e                    op;
    cfg_field_e                 field;
    entry_idx_t                 idx;
    logic [`TLB_CFG_DATA_W-1:0] wdata;
  } cfg_req_t;

  typedef struct packed {
    logic [`TLB_CFG_DATA_W-1:0] rdata;
  } cfg_rsp_t;

endpackage

//--- logic/tlb_consts.svh
// ################################################
// TLB constants
// Address widths, page offset width, table size
// and configuration data width
// ################################################

`ifndef TLB_CONSTS_SVH
`define TLB_CONSTS_SVH

// Input address space width
`define TLB_INP_ADDR_W 32

// Output address space width
`define TLB_OUP_ADDR_W 32

// 4 KiB pages
`define TLB_PAGE_OFS_W 12

// Number of translation table entries
`define TLB_NUM_ENTRIES 8

// Configuration port data width
`define TLB_CFG_DATA_W 32

`endif
